// File: hw/systolic_pkg.sv
`default_nettype none

package systolic_pkg;

  // Q4.12 operand, used for the left operands and the up weights
  typedef logic signed [15:0] operand_t;

  // Q4.12 dot-product result, truncated and wrapping
  typedef logic signed [15:0] result_t;

  // Q8.24 product of two operands
  typedef logic signed [31:0] product_t;

  // Headroom for long vectors before truncation
  typedef logic signed [39:0] acc_t;

  // Shift from product scale back to result scale
  // Result sits in accumulator bits 27 down to 12
  localparam int FRAC_BITS = 12;

  // Element control states
  typedef enum logic {
    IDLE_ACC = 1'b0,
    EXPORT   = 1'b1
  } pe_state_t;

endpackage

`default_nettype wire

// File: hw/axis_if.sv
`timescale 1ns/100ps
`default_nettype none

// Valid/ready stream with last marker
// A word moves on a cycle where valid and ready are both high
interface axis_if;

  // Payload, every stream in the row carries 16 bits
  systolic_pkg::operand_t data;
  logic                   last;

  // Handshake
  logic                   valid;
  logic                   ready;

  // Producer side
  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  // Consumer side
  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: hw/axis_skid_buffer.sv
`timescale 1ns/100ps
`default_nettype none

// Two-entry skid buffer
// Input ready comes straight from a flop, yet one word per cycle still passes
module axis_skid_buffer (
  input  wire  clk,
  input  wire  reset,
  axis_if.sink   in,
  axis_if.source out
);

  // Last bit rides on top of the data
  localparam int WORD_W = $bits(systolic_pkg::operand_t) + 1;

  // Main entry drives the output
  logic              main_valid;
  logic [WORD_W-1:0] main_word;

  // Skid entry catches the word in flight when output stalls
  logic              skid_valid;
  logic [WORD_W-1:0] skid_word;

  // Registered input ready
  logic              in_ready_r;

  logic [WORD_W-1:0] in_word;
  logic              accept;
  logic              pop;

  assign in_word = {in.last, in.data};
  assign accept  = in.valid & in_ready_r;
  assign pop     = main_valid & out.ready;

  assign in.ready  = in_ready_r;
  assign out.valid = main_valid;
  assign out.data  = main_word[WORD_W-2:0];
  assign out.last  = main_word[WORD_W-1];

  // Occupancy and ready
  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready_r <= 1'b1;
    end else if (skid_valid) begin
      // Both full, input is closed until the main entry drains
      if (pop) begin
        skid_valid <= 1'b0;
        in_ready_r <= 1'b1;
      end
    end else if (accept) begin
      if (main_valid && !pop) begin
        // Output stalled, park the word and close the input
        skid_valid <= 1'b1;
        in_ready_r <= 1'b0;
      end else begin
        main_valid <= 1'b1;
      end
    end else if (pop) begin
      main_valid <= 1'b0;
    end
  end

  // Payload moves with the same decisions
  always_ff @(posedge clk) begin
    if (skid_valid) begin
      // Refill main from skid
      if (pop) begin
        main_word <= skid_word;
      end
    end else if (accept) begin
      if (main_valid && !pop) begin
        skid_word <= in_word;
      end else begin
        main_word <= in_word;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/pe_control.sv
`timescale 1ns/100ps
`default_nettype none

// Control unit of one element
// Decides when a pair is consumed, when a vector ends and when the result leaves
module pe_control #(
  parameter int PE_POSITION = 0,
  parameter int PE_COUNT    = 4
) (
  input  wire  clk,
  input  wire  reset,

  // Buffered input heads
  input  wire  left_valid,
  input  wire  up_valid,
  input  wire  left_last,
  input  wire  up_last,

  // Downstream readiness
  input  wire  right_ready,
  input  wire  down_ready,

  output logic consume,
  output logic first_pair,
  output logic export_rslt,
  output logic err_unaligned
);

  // Last element has no right neighbour, its operands are dropped
  localparam bit IS_LAST = (PE_POSITION == PE_COUNT - 1);

  systolic_pkg::pe_state_t state;
  systolic_pkg::pe_state_t state_next;

  // Next consumed pair opens a new vector
  logic new_vector;
  logic pair_last;

  assign pair_last = left_last | up_last;

  // Both heads present, no result waiting, right side can take the operand
  assign consume = left_valid & up_valid &
                   (state == systolic_pkg::IDLE_ACC) &
                   (right_ready | IS_LAST);

  assign first_pair  = new_vector;
  assign export_rslt = (state == systolic_pkg::EXPORT);

  always_comb begin
    state_next = state;
    case (state)
      systolic_pkg::IDLE_ACC: begin
        // End of vector on either stream
        if (consume && pair_last) begin
          state_next = systolic_pkg::EXPORT;
        end
      end
      systolic_pkg::EXPORT: begin
        // Hold the result until the down side takes it
        if (down_ready) begin
          state_next = systolic_pkg::IDLE_ACC;
        end
      end
      default: state_next = systolic_pkg::IDLE_ACC;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= systolic_pkg::IDLE_ACC;
      new_vector    <= 1'b1;
      err_unaligned <= 1'b0;
    end else begin
      state <= state_next;
      if (consume) begin
        new_vector <= pair_last;
      end
      // One-cycle pulse when only one stream ends here
      err_unaligned <= consume & (left_last ^ up_last);
    end
  end

endmodule

`default_nettype wire

// File: hw/processing_element.sv
`timescale 1ns/100ps
`default_nettype none

// One node of the row
// Multiplies operand and weight pairs, sums them, exports the dot product
module processing_element #(
  parameter int PE_POSITION = 0,
  parameter int PE_COUNT    = 4
) (
  input  wire    clk,
  input  wire    reset,
  axis_if.sink   left,
  axis_if.sink   up,
  axis_if.source right,
  axis_if.source down,
  output wire    err_unaligned
);

  localparam bit IS_LAST = (PE_POSITION == PE_COUNT - 1);

  // Buffered heads of both input streams
  axis_if left_buf ();
  axis_if up_buf ();

  // Control outputs
  logic consume;
  logic first_pair;
  logic export_rslt;

  // Datapath
  systolic_pkg::product_t product;
  systolic_pkg::acc_t     acc;
  systolic_pkg::result_t  result;

  axis_skid_buffer left_skid (
    .clk   (clk),
    .reset (reset),
    .in    (left),
    .out   (left_buf)
  );

  axis_skid_buffer up_skid (
    .clk   (clk),
    .reset (reset),
    .in    (up),
    .out   (up_buf)
  );

  pe_control #(
    .PE_POSITION (PE_POSITION),
    .PE_COUNT    (PE_COUNT)
  ) control (
    .clk           (clk),
    .reset         (reset),
    .left_valid    (left_buf.valid),
    .up_valid      (up_buf.valid),
    .left_last     (left_buf.last),
    .up_last       (up_buf.last),
    .right_ready   (right.ready),
    .down_ready    (down.ready),
    .consume       (consume),
    .first_pair    (first_pair),
    .export_rslt   (export_rslt),
    .err_unaligned (err_unaligned)
  );

  // Both heads leave together
  assign left_buf.ready = consume;
  assign up_buf.ready   = consume;

  // Signed Q4.12 times Q4.12 gives Q8.24
  assign product = left_buf.data * up_buf.data;

  // First pair of a vector loads, later pairs add
  always_ff @(posedge clk) begin
    if (consume) begin
      if (first_pair) begin
        acc <= systolic_pkg::acc_t'(product);
      end else begin
        acc <= acc + systolic_pkg::acc_t'(product);
      end
    end
  end

  // Truncate back to Q4.12, upper bits wrap away
  assign result = acc[systolic_pkg::FRAC_BITS +: $bits(systolic_pkg::result_t)];

  // Operand forwarding
  // Offered only while a pair could be consumed, so valid holds until it moves
  // Last element keeps right valid low
  assign right.data  = left_buf.data;
  assign right.last  = left_buf.last;
  assign right.valid = IS_LAST ? 1'b0 : (left_buf.valid & up_buf.valid & ~export_rslt);

  // Result output
  // Down last marks the bottom lane of the row
  assign down.data  = result;
  assign down.valid = export_rslt;
  assign down.last  = IS_LAST;

endmodule

`default_nettype wire

// File: hw/pe_row.sv
`timescale 1ns/100ps
`default_nettype none

// One row of the systolic array
// Shared operand stream runs left to right, each lane has its own weights and result
module pe_row #(
  parameter int PE_COUNT = 4
) (
  input  wire clk,
  input  wire reset,

  // Shared operand input
  input  wire systolic_pkg::operand_t left_data,
  input  wire                         left_valid,
  output wire                         left_ready,
  input  wire                         left_last,

  // Per-lane weights
  input  wire systolic_pkg::operand_t [PE_COUNT-1:0] up_data,
  input  wire [PE_COUNT-1:0]                         up_valid,
  output wire [PE_COUNT-1:0]                         up_ready,
  input  wire [PE_COUNT-1:0]                         up_last,

  // Per-lane results
  output wire systolic_pkg::result_t [PE_COUNT-1:0] down_data,
  output wire [PE_COUNT-1:0]                        down_valid,
  input  wire [PE_COUNT-1:0]                        down_ready,
  output wire [PE_COUNT-1:0]                        down_last,

  output wire [PE_COUNT-1:0] err_unaligned
);

  // Operand chain, link j feeds element j
  axis_if left_chain [PE_COUNT+1] ();

  assign left_chain[0].data  = left_data;
  assign left_chain[0].valid = left_valid;
  assign left_chain[0].last  = left_last;
  assign left_ready          = left_chain[0].ready;

  // Nothing sits right of the last element
  assign left_chain[PE_COUNT].ready = 1'b1;

  for (genvar j = 0; j < PE_COUNT; j++) begin : g_pe
    axis_if up_if ();
    axis_if down_if ();

    assign up_if.data  = up_data[j];
    assign up_if.valid = up_valid[j];
    assign up_if.last  = up_last[j];
    assign up_ready[j] = up_if.ready;

    assign down_data[j]  = down_if.data;
    assign down_valid[j] = down_if.valid;
    assign down_last[j]  = down_if.last;
    assign down_if.ready = down_ready[j];

    processing_element #(
      .PE_POSITION (j),
      .PE_COUNT    (PE_COUNT)
    ) pe (
      .clk           (clk),
      .reset         (reset),
      .left          (left_chain[j]),
      .up            (up_if),
      .right         (left_chain[j+1]),
      .down          (down_if),
      .err_unaligned (err_unaligned[j])
    );
  end

endmodule

`default_nettype wire

// File: test/pe_row_sva.sv
`timescale 1ns/100ps
`default_nettype none

// Stream rules at the row boundary
module pe_row_sva #(
  parameter int PE_COUNT = 4
) (
  input wire                                       clk,
  input wire                                       reset,
  input wire systolic_pkg::operand_t               left_data,
  input wire                                       left_valid,
  input wire                                       left_ready,
  input wire                                       left_last,
  input wire systolic_pkg::result_t [PE_COUNT-1:0] down_data,
  input wire [PE_COUNT-1:0]                        down_valid,
  input wire [PE_COUNT-1:0]                        down_ready,
  input wire [PE_COUNT-1:0]                        err_unaligned
);

  // Running count of failed stream rules
  int fail_count = 0;

  // Operand word held while the row stalls it
  a_left_hold: assert property (
    @(posedge clk) disable iff (reset)
    (left_valid && !left_ready) |=>
      (left_valid && $stable(left_data) && $stable(left_last))
  ) else begin
    $error("left word changed or withdrawn before it moved");
    fail_count++;
  end

  // Outputs quiet in the cycle after reset
  a_reset_quiet: assert property (
    @(posedge clk) reset |=> (down_valid == '0 && err_unaligned == '0)
  ) else begin
    $error("down_valid or err_unaligned high right after reset");
    fail_count++;
  end

  for (genvar j = 0; j < PE_COUNT; j++) begin : g_lane
    // Result held under down back-pressure
    a_down_hold: assert property (
      @(posedge clk) disable iff (reset)
      (down_valid[j] && !down_ready[j]) |=> (down_valid[j] && $stable(down_data[j]))
    ) else begin
      $error("lane %0d result changed or dropped while waiting", j);
      fail_count++;
    end
  end

endmodule

bind pe_row pe_row_sva #(
  .PE_COUNT (PE_COUNT)
) sva (
  .clk           (clk),
  .reset         (reset),
  .left_data     (left_data),
  .left_valid    (left_valid),
  .left_ready    (left_ready),
  .left_last     (left_last),
  .down_data     (down_data),
  .down_valid    (down_valid),
  .down_ready    (down_ready),
  .err_unaligned (err_unaligned)
);

`default_nettype wire

// File: test/pe_row_tb.sv
`timescale 1ns/100ps
`default_nettype none

// Random vectors through a four-lane row checked against a dot-product model
module pe_row_tb;

  localparam int PE_COUNT       = 4;
  localparam int CLK_PERIOD     = 4;
  localparam int NUM_VECTORS    = 40;
  localparam int MAX_LEN        = 8;
  localparam int STALL_CYCLES   = 20;
  localparam int TIMEOUT_CYCLES = (NUM_VECTORS + 1) * MAX_LEN * STALL_CYCLES;

  // Vector whose weights on one lane stop a word early
  localparam int SHORT_VECTOR = 12;
  localparam int SHORT_LANE   = 1;

  logic clk;
  logic reset;

  systolic_pkg::operand_t                left_data;
  logic                                  left_valid;
  logic                                  left_ready;
  logic                                  left_last;
  systolic_pkg::operand_t [PE_COUNT-1:0] up_data;
  logic [PE_COUNT-1:0]                   up_valid;
  logic [PE_COUNT-1:0]                   up_ready;
  logic [PE_COUNT-1:0]                   up_last;
  systolic_pkg::result_t [PE_COUNT-1:0]  down_data;
  logic [PE_COUNT-1:0]                   down_valid;
  logic [PE_COUNT-1:0]                   down_ready;
  logic [PE_COUNT-1:0]                   down_last;
  logic [PE_COUNT-1:0]                   err_unaligned;

  // Stimulus words with the last bit above the 16 data bits
  logic [16:0] left_words [$];
  logic [16:0] up_words [PE_COUNT][$];

  // Model output per lane with the oldest result first
  systolic_pkg::result_t expected [PE_COUNT][$];
  int err_expected [PE_COUNT];
  int err_seen [PE_COUNT];

  int mismatches;
  int failures;

  pe_row #(
    .PE_COUNT (PE_COUNT)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .left_data     (left_data),
    .left_valid    (left_valid),
    .left_ready    (left_ready),
    .left_last     (left_last),
    .up_data       (up_data),
    .up_valid      (up_valid),
    .up_ready      (up_ready),
    .up_last       (up_last),
    .down_data     (down_data),
    .down_valid    (down_valid),
    .down_ready    (down_ready),
    .down_last     (down_last),
    .err_unaligned (err_unaligned)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Directed vector first and then random lengths and values
  task automatic build_stimulus();
    int len;
    int wlen;
    // Same operands meet different weights on each lane
    for (int i = 0; i < 4; i++) begin
      left_words.push_back({i == 3, 16'(4096 - i * 1536)});
      for (int l = 0; l < PE_COUNT; l++) begin
        up_words[l].push_back({i == 3, 16'((l + 1) * 1024 - i * 700)});
      end
    end
    for (int v = 0; v < NUM_VECTORS; v++) begin
      len = 1 + int'($urandom % MAX_LEN);
      if (v == SHORT_VECTOR && len < 2) begin
        len = 2;
      end
      for (int i = 0; i < len; i++) begin
        left_words.push_back({i == len - 1, 16'($urandom)});
      end
      for (int l = 0; l < PE_COUNT; l++) begin
        wlen = (v == SHORT_VECTOR && l == SHORT_LANE) ? len - 1 : len;
        for (int i = 0; i < wlen; i++) begin
          up_words[l].push_back({i == wlen - 1, 16'($urandom)});
        end
        // Extra closing weight pairs with the operand left behind
        if (wlen < len) begin
          up_words[l].push_back({1'b1, 16'($urandom)});
        end
      end
    end
  endtask

  // Pairs words in order per lane and ends a vector on either last bit
  task automatic build_model();
    logic signed [63:0]     sum;
    systolic_pkg::operand_t a;
    systolic_pkg::operand_t w;
    logic [16:0]            lw;
    logic [16:0]            uw;
    for (int l = 0; l < PE_COUNT; l++) begin
      sum = '0;
      err_expected[l] = 0;
      for (int k = 0; k < left_words.size(); k++) begin
        lw  = left_words[k];
        uw  = up_words[l][k];
        a   = lw[15:0];
        w   = uw[15:0];
        sum = sum + a * w;
        if (lw[16] || uw[16]) begin
          // Q8.24 sum back to Q4.12 with the high bits wrapping away
          expected[l].push_back(sum[27:12]);
          if (lw[16] != uw[16]) begin
            err_expected[l]++;
          end
          sum = '0;
        end
      end
    end
  endtask

  task automatic drive_left();
    int gap;
    for (int k = 0; k < left_words.size(); k++) begin
      gap = ($urandom % 4 == 0) ? 1 + int'($urandom % 3) : 0;
      @(negedge clk);
      if (gap > 0) begin
        left_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
      left_data  = left_words[k][15:0];
      left_last  = left_words[k][16];
      left_valid = 1'b1;
      @(posedge clk);
      while (!left_ready) @(posedge clk);
    end
    @(negedge clk);
    left_valid = 1'b0;
  endtask

  task automatic drive_up(input int lane);
    int gap;
    for (int k = 0; k < up_words[lane].size(); k++) begin
      gap = ($urandom % 4 == 0) ? 1 + int'($urandom % 3) : 0;
      @(negedge clk);
      if (gap > 0) begin
        up_valid[lane] = 1'b0;
        repeat (gap) @(negedge clk);
      end
      up_data[lane]  = up_words[lane][k][15:0];
      up_last[lane]  = up_words[lane][k][16];
      up_valid[lane] = 1'b1;
      @(posedge clk);
      while (!up_ready[lane]) @(posedge clk);
    end
    @(negedge clk);
    up_valid[lane] = 1'b0;
  endtask

  task automatic check_after_reset();
    assert (down_valid == '0 && err_unaligned == '0) else begin
      $display("Mismatch at %0t: after reset down_valid %b err_unaligned %b",
               $time, down_valid, err_unaligned);
      mismatches++;
    end
    assert (left_ready && up_ready == '1) else begin
      $display("Mismatch at %0t: after reset left_ready %b up_ready %b",
               $time, left_ready, up_ready);
      mismatches++;
    end
  endtask

  task automatic check_result(input int lane);
    systolic_pkg::result_t want;
    assert (expected[lane].size() > 0) else begin
      $display("Lane %0d sent a result at %0t that no vector accounts for", lane, $time);
      failures++;
    end
    if (expected[lane].size() > 0) begin
      want = expected[lane].pop_front();
      assert (down_data[lane] == want) else begin
        $display("Mismatch at %0t: lane %0d result %h, expected %h",
                 $time, lane, down_data[lane], want);
        mismatches++;
      end
    end
    // Only the bottom lane marks its result as last
    assert (down_last[lane] == (lane == PE_COUNT - 1)) else begin
      $display("Mismatch at %0t: lane %0d down_last %b", $time, lane, down_last[lane]);
      mismatches++;
    end
  endtask

  function automatic bit all_results_in();
    for (int l = 0; l < PE_COUNT; l++) begin
      if (expected[l].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic print_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
  endtask

  // Result and error pulse monitor
  always @(posedge clk) begin
    if (!reset) begin
      for (int l = 0; l < PE_COUNT; l++) begin
        if (err_unaligned[l]) begin
          err_seen[l]++;
        end
        if (down_valid[l] && down_ready[l]) begin
          check_result(l);
        end
      end
    end
  end

  // Random back-pressure on every result lane
  initial begin
    forever begin
      @(negedge clk);
      for (int l = 0; l < PE_COUNT; l++) begin
        down_ready[l] = ($urandom % 3 != 0);
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles with results still outstanding", TIMEOUT_CYCLES);
    print_counts();
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(4));
    reset      = 1'b1;
    left_data  = '0;
    left_valid = 1'b0;
    left_last  = 1'b0;
    up_data    = '0;
    up_valid   = '0;
    up_last    = '0;
    down_ready = '0;
    mismatches = 0;
    failures   = 0;
    build_stimulus();
    build_model();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_after_reset();
    fork
      drive_left();
    join_none
    for (int l = 0; l < PE_COUNT; l++) begin
      fork
        automatic int lane = l;
        drive_up(lane);
      join_none
    end
    wait fork;
    while (!all_results_in()) @(posedge clk);
    // Any extra result or pulse shows up in this quiet stretch
    repeat (4 * MAX_LEN) @(posedge clk);
    for (int l = 0; l < PE_COUNT; l++) begin
      assert (err_seen[l] == err_expected[l]) else begin
        $display("Lane %0d pulsed err_unaligned %0d times where %0d pulses were due",
                 l, err_seen[l], err_expected[l]);
        failures++;
      end
    end
    // Stream rules of the bound checker
    assert (uut.sva.fail_count == 0) else begin
      $display("Stream rule assertions failed %0d times", uut.sva.fail_count);
      failures += uut.sva.fail_count;
    end
    print_counts();
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/systolic_pkg.sv
hw/axis_if.sv
hw/axis_skid_buffer.sv
hw/pe_control.sv
hw/processing_element.sv
hw/pe_row.sv
test/pe_row_sva.sv
test/pe_row_tb.sv
